// File: design/i2c_cmd_pkg.sv
////////////////////////////////////////
// i2c command types
// host command, host result and the read/write opcode
////////////////////////////////////////

`default_nettype none

package i2c_cmd_pkg;

  // read/write bit of the address byte
  typedef enum logic
  {
    op_write = 1'b0,
    op_read  = 1'b1
  } rw_op_e;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] mem_addr_t;

  // one host command, 16 bits
  typedef struct packed
  {
    rw_op_e    op;
    mem_addr_t addr;
    byte_t     din;
  } host_cmd_t;

  // master status back to the host, 11 bits
  typedef struct packed
  {
    byte_t dout;
    logic  busy;
    logic  ack_err; // slave did not ack
    logic  done;    // one cycle at the end
  } host_result_t;

endpackage

`default_nettype wire

// File: design/i2c_bus_pkg.sv
////////////////////////////////////////
// i2c bus types
// line levels, bit phases, FSM states and memory depth
////////////////////////////////////////

`default_nettype none

package i2c_bus_pkg;

  // resolved bus levels
  typedef struct packed
  {
    logic scl;
    logic sda;
  } i2c_line_t;

  // four quarters of one bit period
  typedef enum logic [1:0]
  {
    q0,
    q1,
    q2,
    q3
  } quarter_e;

  typedef enum logic [3:0]
  {
    m_idle,
    m_start,
    m_write_addr,
    m_addr_ack,
    m_write_data,
    m_data_ack,
    m_read_data,
    m_master_nack,
    m_stop
  } master_state_e;

  typedef enum logic [3:0]
  {
    s_idle,
    s_read_addr,
    s_send_ack1,
    s_read_data,
    s_send_ack2,
    s_send_data,
    s_wait_master_ack,
    s_wait_stop
  } slave_state_e;

  localparam int mem_depth = 128; // slave memory size in bytes

endpackage

`default_nettype wire

// File: design/quarter_clock_gen.sv
////////////////////////////////////////
// quarter clock generator
// splits each i2c bit period into four phases
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module quarter_clock_gen
  import i2c_bus_pkg::*;
#(
  parameter int quarter_cycles = 10
)
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic run,
  output quarter_e  phase,
  output logic      bit_end
);

  localparam int cnt_w = (quarter_cycles > 1) ? $clog2(quarter_cycles) : 1;

  logic [cnt_w-1:0] qcnt;
  logic             quarter_end;

  assign quarter_end = (qcnt == cnt_w'(quarter_cycles - 1));

  // held at zero while idle so every transaction starts in q0
  always_ff @(posedge clk)
  begin
    if (rst || !run)
    begin
      qcnt  <= '0;
      phase <= q0;
    end
    else if (quarter_end)
    begin
      qcnt  <= '0;
      phase <= quarter_e'(phase + 2'd1); // q3 wraps to q0
    end
    else
    begin
      qcnt <= qcnt + cnt_w'(1);
    end
  end

  assign bit_end = run && quarter_end && (phase == q3);

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // bit end closes a full q3 that follows q2
  a_bit_end_q3: assert property (@(posedge clk) disable iff (rst)
    bit_end |-> (phase == q3) && ($past(phase, quarter_cycles) == q2));

endmodule

`default_nettype wire

// File: design/i2c_master.sv
////////////////////////////////////////
// i2c master
// takes one host command and runs a single-byte transfer
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2c_master
  import i2c_cmd_pkg::*, i2c_bus_pkg::*;
#(
  parameter int sys_freq = 10_000_000,
  parameter int i2c_freq = 250_000
)
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      newd,
  input  wire host_cmd_t cmd,
  input  wire i2c_line_t line,
  output logic           scl,
  output logic           sda_low,
  output host_result_t   result
);

  localparam int quarter_cycles = sys_freq / i2c_freq / 4;

  master_state_e state;
  quarter_e      phase;
  quarter_e      phase_d;
  logic          bit_end;
  logic          busy;
  logic          accept;
  logic          q2_start;
  logic          last_bit;
  logic          to_stop;
  logic [2:0]    bitcnt;
  logic          err;
  logic          ack_bit;
  logic          done_q;
  logic          ack_err_q;
  byte_t         dout_q;
  byte_t         tx_shift;
  byte_t         rx_shift;
  byte_t         din_q;
  rw_op_e        op_q;

  assign busy     = (state != m_idle);
  assign accept   = (state == m_idle) && newd;
  assign q2_start = (phase == q2) && (phase_d == q1); // ack and read sample point
  assign last_bit = (bitcnt == 3'd7);

  // scl is pulled low early in q3 when the next bit is a stop
  assign to_stop = (state == m_data_ack) || (state == m_master_nack) ||
                   ((state == m_addr_ack) && ack_bit);

  quarter_clock_gen #(
    .quarter_cycles(quarter_cycles)
  ) u_qclk (
    .clk    (clk),
    .rst    (rst),
    .run    (busy),
    .phase  (phase),
    .bit_end(bit_end)
  );

  always_comb
  begin
    case (state)
      m_idle, m_start, m_stop: scl = 1'b1;
      default:                 scl = (phase == q2) || ((phase == q3) && !to_stop);
    endcase
  end

  ////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= m_idle;
      phase_d   <= q0;
      sda_low   <= 1'b0;
      bitcnt    <= '0;
      err       <= 1'b0;
      done_q    <= 1'b0;
      ack_err_q <= 1'b0;
      dout_q    <= '0;
    end
    else
    begin
      phase_d <= phase;
      done_q  <= 1'b0;
      case (state)
        m_idle:
          if (newd)
          begin
            err    <= 1'b0;
            bitcnt <= '0;
            state  <= m_start;
          end
        m_start:
        begin
          if (phase == q2)
            sda_low <= 1'b1; // sda falls with scl high
          if (bit_end)
            state <= m_write_addr;
        end
        m_write_addr, m_write_data:
        begin
          if (phase == q1)
            sda_low <= ~tx_shift[7];
          if (bit_end)
          begin
            bitcnt <= bitcnt + 3'd1;
            if (last_bit)
              state <= (state == m_write_addr) ? m_addr_ack : m_data_ack;
          end
        end
        m_addr_ack, m_data_ack:
        begin
          if (phase == q1)
            sda_low <= 1'b0; // let the slave drive the ack
          if ((phase == q3) && to_stop)
            sda_low <= 1'b1;
          if (bit_end)
          begin
            err <= err | ack_bit;
            if (to_stop)
              state <= m_stop;
            else if (op_q == op_read)
              state <= m_read_data;
            else
              state <= m_write_data;
          end
        end
        m_read_data:
        begin
          if (phase == q1)
            sda_low <= 1'b0;
          if (bit_end)
          begin
            bitcnt <= bitcnt + 3'd1;
            if (last_bit)
              state <= m_master_nack;
          end
        end
        m_master_nack:
        begin
          if (phase == q1)
            sda_low <= 1'b0; // released line is the nack
          if (phase == q3)
            sda_low <= 1'b1;
          if (bit_end)
            state <= m_stop;
        end
        m_stop:
        begin
          if (phase == q2)
            sda_low <= 1'b0; // sda rises with scl high
          if (bit_end)
          begin
            state     <= m_idle;
            done_q    <= 1'b1;
            ack_err_q <= err;
            if ((op_q == op_read) && !err)
              dout_q <= rx_shift;
          end
        end
        default: state <= m_idle;
      endcase
    end
  end

  // shift registers and captured command
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tx_shift <= {cmd.addr, cmd.op};
      din_q    <= cmd.din;
      op_q     <= cmd.op;
    end
    else if (bit_end && ((state == m_write_addr) || (state == m_write_data)))
      tx_shift <= {tx_shift[6:0], 1'b0};
    else if (bit_end && (state == m_addr_ack))
      tx_shift <= din_q;
    if (q2_start)
      ack_bit <= line.sda;
    if (q2_start && (state == m_read_data))
      rx_shift <= {rx_shift[6:0], line.sda}; // msb first
  end

  assign result = '{dout: dout_q, busy: busy, ack_err: ack_err_q, done: done_q};

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_done_ends_busy: assert property (@(posedge clk) disable iff (rst)
    $rose(done_q) |-> !busy && $past(busy));

  // sda only moves under a high scl in start and stop
  a_sda_edge_start_stop: assert property (@(posedge clk) disable iff (rst)
    (line.scl && $past(line.scl) && (line.sda != $past(line.sda))) |->
      ((state == m_start) || (state == m_stop)));

endmodule

`default_nettype wire

// File: design/i2c_slave_mem.sv
////////////////////////////////////////
// i2c slave with 128-byte memory
// acks every address and serves one byte per transfer
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2c_slave_mem
  import i2c_cmd_pkg::*, i2c_bus_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire i2c_line_t line,
  output logic           sda_low
);

  slave_state_e state;
  logic         scl_s1;
  logic         scl_s2;
  logic         scl_d;
  logic         sda_s1;
  logic         sda_s2;
  logic         sda_d;
  logic         scl_rise;
  logic         scl_fall;
  logic         start_det;
  logic         stop_det;
  logic         tx_step;
  logic [2:0]   bitcnt;
  logic         mem_we;
  logic         mem_rd;
  byte_t        rx_shift;
  byte_t        tx_shift;
  mem_addr_t    addr_q;
  rw_op_e       rw_q;
  byte_t        mem [mem_depth];

  ////////////////////////////////////////
  // bus synchronizers and edge detect
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      {scl_s1, scl_s2, scl_d} <= 3'b111; // idle bus is high
      {sda_s1, sda_s2, sda_d} <= 3'b111;
    end
    else
    begin
      scl_s1 <= line.scl;
      scl_s2 <= scl_s1;
      scl_d  <= scl_s2;
      sda_s1 <= line.sda;
      sda_s2 <= sda_s1;
      sda_d  <= sda_s2;
    end
  end

  assign scl_rise  = scl_s2 && !scl_d;
  assign scl_fall  = !scl_s2 && scl_d;
  assign start_det = scl_s2 && scl_d && sda_d && !sda_s2;
  assign stop_det  = scl_s2 && scl_d && !sda_d && sda_s2;

  // next read bit goes out on this falling edge
  assign tx_step = scl_fall && ((state == s_send_data) ||
                   ((state == s_send_ack1) && sda_low && (rw_q == op_read)));

  ////////////////////////////////////////
  // slave FSM
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= s_idle;
      sda_low <= 1'b0;
      bitcnt  <= '0;
      mem_we  <= 1'b0;
      mem_rd  <= 1'b0;
    end
    else
    begin
      mem_we <= 1'b0;
      mem_rd <= 1'b0;
      if (start_det)
      begin
        state   <= s_read_addr;
        bitcnt  <= '0;
        sda_low <= 1'b0;
      end
      else if (stop_det)
      begin
        state   <= s_idle;
        sda_low <= 1'b0;
      end
      else
      begin
        case (state)
          s_read_addr, s_read_data:
            if (scl_rise)
            begin
              bitcnt <= bitcnt + 3'd1;
              if (bitcnt == 3'd7)
              begin
                state  <= (state == s_read_addr) ? s_send_ack1 : s_send_ack2;
                mem_we <= (state == s_read_data);
              end
            end
          s_send_ack1:
            if (scl_rise && sda_low && (rw_q == op_read))
              mem_rd <= 1'b1;
            else if (scl_fall)
            begin
              if (!sda_low)
                sda_low <= 1'b1; // address ack
              else if (rw_q == op_read)
              begin
                sda_low <= ~tx_shift[7];
                bitcnt  <= '0;
                state   <= s_send_data;
              end
              else
              begin
                sda_low <= 1'b0;
                bitcnt  <= '0;
                state   <= s_read_data;
              end
            end
          s_send_ack2:
            if (scl_fall)
            begin
              if (!sda_low)
                sda_low <= 1'b1; // data ack
              else
              begin
                sda_low <= 1'b0;
                state   <= s_wait_stop;
              end
            end
          s_send_data:
            if (scl_fall)
            begin
              bitcnt <= bitcnt + 3'd1;
              if (bitcnt == 3'd7)
              begin
                sda_low <= 1'b0; // hand sda back for the nack
                state   <= s_wait_master_ack;
              end
              else
                sda_low <= ~tx_shift[7];
            end
          s_wait_master_ack:
            if (scl_rise)
              state <= s_wait_stop;
          s_idle, s_wait_stop:
            sda_low <= 1'b0;
          default:
            state <= s_idle;
        endcase
      end
    end
  end

  // shift registers and latched address
  always_ff @(posedge clk)
  begin
    if (scl_rise && ((state == s_read_addr) || (state == s_read_data)))
      rx_shift <= {rx_shift[6:0], sda_s2};
    if (scl_rise && (state == s_read_addr) && (bitcnt == 3'd7))
    begin
      addr_q <= rx_shift[6:0];
      rw_q   <= rw_op_e'(sda_s2); // eighth bit is r/w
    end
    if (mem_rd)
      tx_shift <= mem[addr_q];
    else if (tx_step)
      tx_shift <= {tx_shift[6:0], 1'b0};
  end

  // memory loads the index pattern at reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < mem_depth; i++)
        mem[i] <= byte_t'(i);
    end
    else if (mem_we)
      mem[addr_q] <= rx_shift;
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_write_in_ack2: assert property (@(posedge clk) disable iff (rst)
    mem_we |-> (state == s_send_ack2) && ($past(state) == s_read_data));

endmodule

`default_nettype wire

// File: design/i2c_top.sv
////////////////////////////////////////
// i2c top level
// master and memory slave on one pulled-up bus
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2c_top
  import i2c_cmd_pkg::*, i2c_bus_pkg::*;
#(
  parameter int sys_freq = 10_000_000,
  parameter int i2c_freq = 250_000
)
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      newd,
  input  wire host_cmd_t cmd,
  output host_result_t   result
);

  logic      scl;
  logic      master_sda_low;
  logic      slave_sda_low;
  i2c_line_t line;

  // open drain with pull-up so sda stays high unless pulled low
  assign line.scl = scl;
  assign line.sda = !(master_sda_low || slave_sda_low);

  i2c_master #(
    .sys_freq(sys_freq),
    .i2c_freq(i2c_freq)
  ) u_master (
    .clk    (clk),
    .rst    (rst),
    .newd   (newd),
    .cmd    (cmd),
    .line   (line),
    .scl    (scl),
    .sda_low(master_sda_low),
    .result (result)
  );

  i2c_slave_mem u_slave (
    .clk    (clk),
    .rst    (rst),
    .line   (line),
    .sda_low(slave_sda_low)
  );

endmodule

`default_nettype wire

// File: verif/i2c_tb_checks.svh
////////////////////////////////////////
// testbench compare and wait tasks
////////////////////////////////////////

`ifndef i2c_tb_checks_svh
`define i2c_tb_checks_svh

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
  if (act !== exp)
  begin
    err_count++;
    $display("FAIL %s: expected %02h, actual %02h", name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp)
  begin
    err_count++;
    $display("FAIL %s: expected %0b, actual %0b", name, exp, act);
  end
endtask

task automatic wait_idle(input string name, output logic seen);
  int n;
  seen = 1'b0;
  n    = 0;
  while (!seen && n < idle_timeout)
  begin
    @(negedge clk);
    n++;
    if (!result.busy)
      seen = 1'b1;
  end
  if (!seen)
  begin
    timeout_count++;
    $display("timeout: busy never dropped before %s", name);
  end
endtask

// done lasts one cycle, so look on every falling edge
task automatic wait_done(input string name, input logic poke, input host_cmd_t poke_cmd,
                         output logic seen, output logic busy_held);
  int n;
  seen      = 1'b0;
  busy_held = 1'b1;
  n         = 0;
  while (!seen && n < done_timeout)
  begin
    @(negedge clk);
    n++;
    if (poke && (n == 4))
    begin
      cmd  = poke_cmd; // stray command, must be ignored
      newd = 1'b1;
    end
    else
      newd = 1'b0;
    if (result.done)
      seen = 1'b1;
    else if (!result.busy)
      busy_held = 1'b0;
  end
  if (!seen)
  begin
    timeout_count++;
    $display("timeout: %s saw no done within %0d cycles", name, done_timeout);
  end
endtask

`endif

// File: verif/i2c_tb.sv
////////////////////////////////////////
// i2c master and memory slave testbench
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2c_tb
  import i2c_cmd_pkg::*, i2c_bus_pkg::*;
;

  localparam int n_vec        = 14;
  localparam int done_timeout = 2000; // about twice one transfer
  localparam int idle_timeout = 100;

  typedef struct packed
  {
    rw_op_e    op;
    mem_addr_t addr;
    byte_t     din;
    logic      poke; // newd pulse while busy
  } vec_t;

  logic         clk;
  logic         rst;
  logic         newd;
  host_cmd_t    cmd;
  host_result_t result;
  int           err_count = 0;
  int           timeout_count = 0;
  logic [31:0]  lfsr = 32'h71e4;
  byte_t        ref_mem [mem_depth];

  vec_t vec_tab [n_vec] = '{
    '{op_read,  7'h05, 8'h00, 1'b0},
    '{op_read,  7'h7f, 8'h00, 1'b0},
    '{op_write, 7'h22, 8'ha5, 1'b0},
    '{op_read,  7'h22, 8'h00, 1'b0},
    '{op_read,  7'h21, 8'h00, 1'b0},
    '{op_read,  7'h23, 8'h00, 1'b0},
    '{op_write, 7'h40, 8'h3c, 1'b1},
    '{op_read,  7'h41, 8'h00, 1'b0},
    '{op_read,  7'h40, 8'h00, 1'b0},
    '{op_read,  7'h00, 8'h00, 1'b1},
    '{op_read,  7'h01, 8'h00, 1'b0},
    '{op_write, 7'h7f, 8'h00, 1'b0},
    '{op_read,  7'h7f, 8'h00, 1'b0},
    '{op_read,  7'h7e, 8'h00, 1'b0}
  };

  string vec_name [n_vec] = '{
    "read_idx_05", "read_idx_7f", "write_22", "read_22", "read_21", "read_23",
    "write_40_poke", "read_41_after_poke", "read_40", "read_00_poke",
    "read_01_after_poke", "write_7f", "read_7f", "read_7e"
  };

  i2c_top #(
    .sys_freq(10_000_000),
    .i2c_freq(250_000)
  ) UUT (
    .clk   (clk),
    .rst   (rst),
    .newd  (newd),
    .cmd   (cmd),
    .result(result)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  `include "i2c_tb_checks.svh"

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[6:0], fb};
    end
    return v;
  endfunction

  task automatic run_transfer(input string name, input rw_op_e rw, input mem_addr_t addr,
                              input byte_t din, input logic poke);
    host_cmd_t poke_cmd;
    logic      seen;
    logic      busy_held;
    poke_cmd = '{op: op_write, addr: addr ^ 7'h01, din: ~din};
    wait_idle(name, seen);
    if (!seen)
      return;
    cmd  = '{op: rw, addr: addr, din: din};
    newd = 1'b1;
    @(negedge clk);
    newd = 1'b0;
    check_flag({name, "_busy_rise"}, 1'b1, result.busy);
    wait_done(name, poke, poke_cmd, seen, busy_held);
    if (!seen)
      return;
    check_flag({name, "_busy_held"}, 1'b1, busy_held);
    check_flag({name, "_busy_at_done"}, 1'b0, result.busy);
    check_flag({name, "_ack_err"}, 1'b0, result.ack_err);
    if (rw == op_read)
      check_byte(name, ref_mem[addr], result.dout);
    else
      ref_mem[addr] = din; // model follows every table write
    @(negedge clk);
    check_flag({name, "_done_width"}, 1'b0, result.done);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin : main_seq
    mem_addr_t a;
    byte_t     d;
    rst  = 1'b1;
    newd = 1'b0;
    cmd  = '0;
    for (int i = 0; i < mem_depth; i++)
      ref_mem[i] = byte_t'(i);
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("reset_busy", 1'b0, result.busy);
    check_flag("reset_done", 1'b0, result.done);
    check_flag("reset_ack_err", 1'b0, result.ack_err);

    for (int i = 0; (i < n_vec) && (timeout_count == 0); i++)
      run_transfer(vec_name[i], vec_tab[i].op, vec_tab[i].addr, vec_tab[i].din,
                   vec_tab[i].poke);

    for (int i = 0; (i < 20) && (timeout_count == 0); i++)
    begin
      a = mem_addr_t'(take_bits(7));
      d = take_bits(8);
      run_transfer($sformatf("rand_wr_%0d", i), op_write, a, d, 1'b0);
      run_transfer($sformatf("rand_rd_%0d", i), op_read, a, 8'h00, 1'b0);
    end

    $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
    if ((err_count == 0) && (timeout_count == 0))
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verif
design/i2c_cmd_pkg.sv
design/i2c_bus_pkg.sv
design/quarter_clock_gen.sv
design/i2c_master.sv
design/i2c_slave_mem.sv
design/i2c_top.sv
verif/i2c_tb.sv

// File: Bender.yml
package:
  name: i2c_mem

sources:
  - files:
      - design/i2c_cmd_pkg.sv
      - design/i2c_bus_pkg.sv
      - design/quarter_clock_gen.sv
      - design/i2c_master.sv
      - design/i2c_slave_mem.sv
      - design/i2c_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/i2c_tb.sv
